//--- source/axil_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI-Lite bus field types
// Address, data, strobe, protection and response widths plus the
// response codes used on the B and R channels
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package axil_pkg;

    // Byte address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // One strobe bit per data byte
    typedef logic [$bits(data_t)/8-1:0] strb_t;

    // Passed along, not interpreted by the target
    typedef logic [2:0] prot_t;

    typedef logic [1:0] resp_t;

    // Response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

//--- source/regmap_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register map of the target bank
// Bank size, word index type and the address bits that select a word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package regmap_pkg;

    localparam int unsigned REG_COUNT = 8;

    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

    // Word index taken from address bits 4 down to 2
    localparam int unsigned IDX_LSB = 2;
    localparam int unsigned IDX_MSB = IDX_LSB + $bits(reg_idx_t) - 1;

    // Any set bit above IDX_MSB means out of range
    localparam int unsigned RANGE_LSB = IDX_MSB + 1;

endpackage

//--- source/axil_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI-Lite interface
// All five channels with master and slave views
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface axil_if;

    import axil_pkg::*;

    // Write address
    addr_t aw_addr;
    prot_t aw_prot;
    logic  aw_valid;
    logic  aw_ready;

    // Write data
    data_t w_data;
    strb_t w_strb;
    logic  w_valid;
    logic  w_ready;

    // Write response
    resp_t b_resp;
    logic  b_valid;
    logic  b_ready;

    // Read address
    addr_t ar_addr;
    prot_t ar_prot;
    logic  ar_valid;
    logic  ar_ready;

    // Read data
    data_t r_data;
    resp_t r_resp;
    logic  r_valid;
    logic  r_ready;

    modport master (
        output aw_addr, aw_prot, aw_valid, w_data, w_strb, w_valid,
        output b_ready, ar_addr, ar_prot, ar_valid, r_ready,
        input  aw_ready, w_ready, b_resp, b_valid, ar_ready,
        input  r_data, r_resp, r_valid
    );

    modport slave (
        input  aw_addr, aw_prot, aw_valid, w_data, w_strb, w_valid,
        input  b_ready, ar_addr, ar_prot, ar_valid, r_ready,
        output aw_ready, w_ready, b_resp, b_valid, ar_ready,
        output r_data, r_resp, r_valid
    );

endinterface

//--- source/axil_pause_gate.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI-Lite pause gate
// Passes all channels through, caps outstanding transactions and
// drains the bus before acknowledging a pause request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module axil_pause_gate #(
    parameter int unsigned MAX_TRANS = 3
) (
    input  logic   seq,
    input  logic   rst_n,
    input  logic   pause_req,
    output logic   pause_ack,
    axil_if.slave  slv,
    axil_if.master mst
);

    // One spare bit above what MAX_TRANS needs
    localparam int unsigned CNT_W = $clog2(MAX_TRANS + 1) + 1;

    typedef logic [CNT_W-1:0] cnt_t;

    typedef enum logic [1:0] {
        ST_RUNNING,
        ST_DRAINING,
        ST_PAUSED
    } phase_t;

    localparam cnt_t CNT_MAX = cnt_t'(MAX_TRANS);

    phase_t state;
    phase_t state_nxt;

    cnt_t aw_cnt;
    cnt_t w_cnt;
    cnt_t ar_cnt;
    cnt_t aw_cnt_nxt;
    cnt_t w_cnt_nxt;
    cnt_t ar_cnt_nxt;

    logic [4:0] en;
    logic [4:0] en_nxt;
    logic       aw_open;
    logic       w_open;
    logic       ar_open;
    logic       drained;

    // Enable bit positions
    localparam int unsigned EN_AW = 0;
    localparam int unsigned EN_W  = 1;
    localparam int unsigned EN_B  = 2;
    localparam int unsigned EN_AR = 3;
    localparam int unsigned EN_R  = 4;

    // Request channels also close at the limit
    assign aw_open = en[EN_AW] && (aw_cnt != CNT_MAX);
    assign w_open  = en[EN_W]  && (w_cnt  != CNT_MAX);
    assign ar_open = en[EN_AR] && (ar_cnt != CNT_MAX);

    assign mst.aw_addr  = slv.aw_addr;
    assign mst.aw_prot  = slv.aw_prot;
    assign mst.aw_valid = aw_open && slv.aw_valid;
    assign slv.aw_ready = aw_open && mst.aw_ready;

    assign mst.w_data   = slv.w_data;
    assign mst.w_strb   = slv.w_strb;
    assign mst.w_valid  = w_open && slv.w_valid;
    assign slv.w_ready  = w_open && mst.w_ready;

    assign slv.b_resp   = mst.b_resp;
    assign slv.b_valid  = en[EN_B] && mst.b_valid;
    assign mst.b_ready  = en[EN_B] && slv.b_ready;

    assign mst.ar_addr  = slv.ar_addr;
    assign mst.ar_prot  = slv.ar_prot;
    assign mst.ar_valid = ar_open && slv.ar_valid;
    assign slv.ar_ready = ar_open && mst.ar_ready;

    assign slv.r_data   = mst.r_data;
    assign slv.r_resp   = mst.r_resp;
    assign slv.r_valid  = en[EN_R] && mst.r_valid;
    assign mst.r_ready  = en[EN_R] && slv.r_ready;

    assign pause_ack = (state == ST_PAUSED);

    // Counts after this edge, frozen while paused
    always_comb begin
        aw_cnt_nxt = aw_cnt;
        w_cnt_nxt  = w_cnt;
        ar_cnt_nxt = ar_cnt;
        if (state != ST_PAUSED) begin
            if (mst.aw_valid && mst.aw_ready) aw_cnt_nxt = aw_cnt_nxt + 1'b1;
            if (mst.w_valid && mst.w_ready)   w_cnt_nxt  = w_cnt_nxt + 1'b1;
            if (mst.b_valid && mst.b_ready) begin
                aw_cnt_nxt = aw_cnt_nxt - 1'b1;
                w_cnt_nxt  = w_cnt_nxt - 1'b1;
            end
            if (mst.ar_valid && mst.ar_ready) ar_cnt_nxt = ar_cnt_nxt + 1'b1;
            if (mst.r_valid && mst.r_ready)   ar_cnt_nxt = ar_cnt_nxt - 1'b1;
        end
    end

    assign drained = (aw_cnt_nxt == '0) && (w_cnt_nxt == '0) && (ar_cnt_nxt == '0);

    always_comb begin
        state_nxt = state;
        en_nxt    = en;
        case (state)
            ST_PAUSED: begin
                if (!pause_req) begin
                    state_nxt = ST_RUNNING;
                    en_nxt    = '1;
                end
            end
            ST_RUNNING, ST_DRAINING: begin
                if (pause_req) begin
                    state_nxt = drained ? ST_PAUSED : ST_DRAINING;
                    // Lagging write channel stays open until it catches up
                    en_nxt[EN_AW] = en[EN_AW] && (aw_cnt_nxt < w_cnt_nxt);
                    en_nxt[EN_W]  = en[EN_W] && (w_cnt_nxt < aw_cnt_nxt);
                    en_nxt[EN_B]  = en[EN_B] && ((aw_cnt_nxt != '0) || (w_cnt_nxt != '0));
                    en_nxt[EN_AR] = 1'b0;
                    en_nxt[EN_R]  = en[EN_R] && (ar_cnt_nxt != '0);
                end else if (state == ST_DRAINING) begin
                    // Request withdrawn before the drain finished
                    state_nxt = ST_RUNNING;
                    en_nxt    = '1;
                end
            end
            default: begin
                state_nxt = ST_PAUSED;
                en_nxt    = '0;
            end
        endcase
    end

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            state  <= ST_PAUSED;
            en     <= '0;
            aw_cnt <= '0;
            w_cnt  <= '0;
            ar_cnt <= '0;
        end else begin
            state  <= state_nxt;
            en     <= en_nxt;
            aw_cnt <= aw_cnt_nxt;
            w_cnt  <= w_cnt_nxt;
            ar_cnt <= ar_cnt_nxt;
        end
    end

endmodule

//--- source/axil_reg_target.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI-Lite register target
// Eight strobed words answered through fixed-depth response pipelines
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module axil_reg_target #(
    parameter int unsigned RESP_DELAY = 4
) (
    input logic   seq,
    input logic   rst_n,
    axil_if.slave bus
);

    import axil_pkg::*;
    import regmap_pkg::*;

    data_t regs [REG_COUNT];

    // Write side carries only the response code
    logic [RESP_DELAY-1:0] wr_vld;
    resp_t                 wr_resp [RESP_DELAY];

    logic [RESP_DELAY-1:0] rd_vld;
    data_t                 rd_data [RESP_DELAY];
    resp_t                 rd_resp [RESP_DELAY];

    logic     wr_adv;
    logic     rd_adv;
    logic     wr_acc;
    logic     rd_acc;
    logic     wr_hit;
    logic     rd_hit;
    reg_idx_t wr_idx;
    reg_idx_t rd_idx;

    // A pipeline moves only when its last stage is empty or being taken
    assign wr_adv = !wr_vld[RESP_DELAY-1] || bus.b_ready;
    assign rd_adv = !rd_vld[RESP_DELAY-1] || bus.r_ready;

    // AW and W transfer together
    assign bus.aw_ready = wr_adv && bus.w_valid;
    assign bus.w_ready  = wr_adv && bus.aw_valid;
    assign bus.ar_ready = rd_adv;

    assign wr_acc = wr_adv && bus.aw_valid && bus.w_valid;
    assign rd_acc = rd_adv && bus.ar_valid;

    // Address decode
    assign wr_idx = bus.aw_addr[IDX_MSB:IDX_LSB];
    assign rd_idx = bus.ar_addr[IDX_MSB:IDX_LSB];
    assign wr_hit = ~|bus.aw_addr[$bits(addr_t)-1:RANGE_LSB];
    assign rd_hit = ~|bus.ar_addr[$bits(addr_t)-1:RANGE_LSB];

    assign bus.b_valid = wr_vld[RESP_DELAY-1];
    assign bus.b_resp  = wr_resp[RESP_DELAY-1];
    assign bus.r_valid = rd_vld[RESP_DELAY-1];
    assign bus.r_data  = rd_data[RESP_DELAY-1];
    assign bus.r_resp  = rd_resp[RESP_DELAY-1];

    // Strobed bytes land on the accepting edge
    always_ff @(posedge seq) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_acc && wr_hit) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (bus.w_strb[b]) begin
                    regs[wr_idx][8*b +: 8] <= bus.w_data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            wr_vld <= '0;
            rd_vld <= '0;
        end else begin
            if (wr_adv) wr_vld <= (wr_vld << 1) | RESP_DELAY'(wr_acc);
            if (rd_adv) rd_vld <= (rd_vld << 1) | RESP_DELAY'(rd_acc);
        end
    end

    always_ff @(posedge seq) begin
        if (wr_adv) begin
            for (int i = RESP_DELAY - 1; i > 0; i--) begin
                wr_resp[i] <= wr_resp[i-1];
            end
            wr_resp[0] <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_adv) begin
            for (int i = RESP_DELAY - 1; i > 0; i--) begin
                rd_data[i] <= rd_data[i-1];
                rd_resp[i] <= rd_resp[i-1];
            end
            // Out of range reads return zero
            rd_data[0] <= rd_hit ? regs[rd_idx] : '0;
            rd_resp[0] <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

//--- source/axil_pause_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pause gate top level
// Plain AXI-Lite ports into the gate, register target behind it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module axil_pause_top #(
    parameter int unsigned MAX_TRANS  = 3,
    parameter int unsigned RESP_DELAY = 4
) (
    input  logic            seq,
    input  logic            rst_n,
    input  logic            pause_req,
    output logic            pause_ack,
    input  axil_pkg::addr_t aw_addr,
    input  axil_pkg::prot_t aw_prot,
    input  logic            aw_valid,
    output logic            aw_ready,
    input  axil_pkg::data_t w_data,
    input  axil_pkg::strb_t w_strb,
    input  logic            w_valid,
    output logic            w_ready,
    output axil_pkg::resp_t b_resp,
    output logic            b_valid,
    input  logic            b_ready,
    input  axil_pkg::addr_t ar_addr,
    input  axil_pkg::prot_t ar_prot,
    input  logic            ar_valid,
    output logic            ar_ready,
    output axil_pkg::data_t r_data,
    output axil_pkg::resp_t r_resp,
    output logic            r_valid,
    input  logic            r_ready
);

    axil_if up_bus ();
    axil_if dn_bus ();

    // Requester side
    assign up_bus.aw_addr  = aw_addr;
    assign up_bus.aw_prot  = aw_prot;
    assign up_bus.aw_valid = aw_valid;
    assign aw_ready        = up_bus.aw_ready;
    assign up_bus.w_data   = w_data;
    assign up_bus.w_strb   = w_strb;
    assign up_bus.w_valid  = w_valid;
    assign w_ready         = up_bus.w_ready;
    assign b_resp          = up_bus.b_resp;
    assign b_valid         = up_bus.b_valid;
    assign up_bus.b_ready  = b_ready;
    assign up_bus.ar_addr  = ar_addr;
    assign up_bus.ar_prot  = ar_prot;
    assign up_bus.ar_valid = ar_valid;
    assign ar_ready        = up_bus.ar_ready;
    assign r_data          = up_bus.r_data;
    assign r_resp          = up_bus.r_resp;
    assign r_valid         = up_bus.r_valid;
    assign up_bus.r_ready  = r_ready;

    axil_pause_gate #(
        .MAX_TRANS (MAX_TRANS)
    ) u_gate (
        .seq       (seq),
        .rst_n     (rst_n),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .slv       (up_bus.slave),
        .mst       (dn_bus.master)
    );

    axil_reg_target #(
        .RESP_DELAY (RESP_DELAY)
    ) u_target (
        .seq   (seq),
        .rst_n (rst_n),
        .bus   (dn_bus.slave)
    );

endmodule

//--- testbench/tb_axil_pause_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AXI-Lite pause gate with its register target
// Random traffic, pause and resume, reference register model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_axil_pause_top;

    import axil_pkg::*;
    import regmap_pkg::*;

    localparam int MAX_TRANS  = 3;
    localparam int RESP_DELAY = 4;
    localparam int CLK_PERIOD = 100;
    localparam int N_RAND     = 24;
    // Two batches of writes and reads plus the final read-back
    localparam int N_TRANS    = 4 * N_RAND + REG_COUNT;
    localparam int PAUSE_CYC  = 60;
    localparam int WDOG_CYC   = N_TRANS * (RESP_DELAY + 20) + PAUSE_CYC;

    logic  seq;
    logic  rst_n;
    logic  pause_req;
    logic  pause_ack;
    addr_t aw_addr;
    prot_t aw_prot;
    logic  aw_valid;
    logic  aw_ready;
    data_t w_data;
    strb_t w_strb;
    logic  w_valid;
    logic  w_ready;
    resp_t b_resp;
    logic  b_valid;
    logic  b_ready;
    addr_t ar_addr;
    prot_t ar_prot;
    logic  ar_valid;
    logic  ar_ready;
    data_t r_data;
    resp_t r_resp;
    logic  r_valid;
    logic  r_ready;

    int    seed;
    int    errors;
    int    wr_hs;
    int    rd_hs;
    int    wr_outst;
    int    rd_outst;
    logic  boot_phase;
    logic  streams_done;

    // Reference model and expected responses in address order
    data_t ref_regs [REG_COUNT];
    resp_t exp_b_q [$];
    data_t exp_rd_q [$];
    resp_t exp_rr_q [$];
    addr_t wr_addr_q [$];
    resp_t exp_b_head;
    data_t exp_rd_head;
    resp_t exp_rr_head;

    // Pre-generated stimulus
    addr_t wr_addr_tab [2*N_RAND];
    data_t wr_data_tab [2*N_RAND];
    strb_t wr_strb_tab [2*N_RAND];
    addr_t rd_addr_tab [2*N_RAND];

    axil_pause_top #(
        .MAX_TRANS  (MAX_TRANS),
        .RESP_DELAY (RESP_DELAY)
    ) UUT (
        .seq       (seq),
        .rst_n     (rst_n),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .aw_addr   (aw_addr),
        .aw_prot   (aw_prot),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w_data    (w_data),
        .w_strb    (w_strb),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b_resp    (b_resp),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .ar_addr   (ar_addr),
        .ar_prot   (ar_prot),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .r_data    (r_data),
        .r_resp    (r_resp),
        .r_valid   (r_valid),
        .r_ready   (r_ready)
    );

    initial begin
        seq = 1'b0;
        forever #(CLK_PERIOD/2) seq = ~seq;
    end

    function automatic logic in_map(input addr_t addr);
        return ~|addr[$bits(addr_t)-1:RANGE_LSB];
    endfunction

    function automatic reg_idx_t word_index(input addr_t addr);
        return addr[IDX_MSB:IDX_LSB];
    endfunction

    function automatic void apply_write(input addr_t addr, input data_t data, input strb_t strb);
        if (in_map(addr)) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (strb[b]) ref_regs[word_index(addr)][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    // About one address in four lands beyond the map
    function automatic addr_t pick_addr();
        addr_t a;
        a = $random(seed);
        if (($random(seed) & 3) == 0) a[8] = 1'b1;
        else a[$bits(addr_t)-1:RANGE_LSB] = '0;
        return a;
    endfunction

    // Port-side model with reads sampled before the same-edge write lands
    always @(posedge seq) begin
        if (rst_n) begin
            if (ar_valid && ar_ready) begin
                exp_rd_q.push_back(in_map(ar_addr) ? ref_regs[word_index(ar_addr)] : '0);
                exp_rr_q.push_back(in_map(ar_addr) ? RESP_OKAY : RESP_SLVERR);
                rd_outst++;
                rd_hs++;
            end
            if (aw_valid && aw_ready) begin
                exp_b_q.push_back(in_map(aw_addr) ? RESP_OKAY : RESP_SLVERR);
                wr_addr_q.push_back(aw_addr);
                wr_outst++;
                wr_hs++;
            end
            if (w_valid && w_ready && wr_addr_q.size() > 0) begin
                apply_write(wr_addr_q.pop_front(), w_data, w_strb);
            end
            if (b_valid && b_ready && exp_b_q.size() > 0) begin
                void'(exp_b_q.pop_front());
                wr_outst--;
            end
            if (r_valid && r_ready && exp_rd_q.size() > 0) begin
                void'(exp_rd_q.pop_front());
                void'(exp_rr_q.pop_front());
                rd_outst--;
            end
            exp_b_head  = (exp_b_q.size() > 0) ? exp_b_q[0] : RESP_OKAY;
            exp_rd_head = (exp_rd_q.size() > 0) ? exp_rd_q[0] : '0;
            exp_rr_head = (exp_rr_q.size() > 0) ? exp_rr_q[0] : RESP_OKAY;
        end
    end

    chk_boot_closed: assert property (@(posedge seq) disable iff (!rst_n)
        boot_phase |-> pause_ack && !aw_ready && !w_ready && !ar_ready)
        else begin
            errors++;
            $display("%0t: a request channel opened before the first resume", $time);
        end

    chk_b_expected: assert property (@(posedge seq) disable iff (!rst_n)
        b_valid && b_ready |-> wr_outst > 0)
        else begin
            errors++;
            $display("%0t: B response arrived with no write outstanding", $time);
        end

    chk_b_resp: assert property (@(posedge seq) disable iff (!rst_n)
        b_valid && b_ready && wr_outst > 0 |-> b_resp == exp_b_head)
        else begin
            errors++;
            $display("FAIL %0t b_resp expected %h actual %h", $time,
                     $sampled(exp_b_head), $sampled(b_resp));
        end

    chk_r_expected: assert property (@(posedge seq) disable iff (!rst_n)
        r_valid && r_ready |-> rd_outst > 0)
        else begin
            errors++;
            $display("%0t: R beat arrived with no read outstanding", $time);
        end

    chk_r_data: assert property (@(posedge seq) disable iff (!rst_n)
        r_valid && r_ready && rd_outst > 0 |-> r_data == exp_rd_head)
        else begin
            errors++;
            $display("FAIL %0t r_data expected %h actual %h", $time,
                     $sampled(exp_rd_head), $sampled(r_data));
        end

    chk_r_resp: assert property (@(posedge seq) disable iff (!rst_n)
        r_valid && r_ready && rd_outst > 0 |-> r_resp == exp_rr_head)
        else begin
            errors++;
            $display("FAIL %0t r_resp expected %h actual %h", $time,
                     $sampled(exp_rr_head), $sampled(r_resp));
        end

    chk_limit: assert property (@(posedge seq) disable iff (!rst_n)
        wr_outst <= MAX_TRANS && rd_outst <= MAX_TRANS)
        else begin
            errors++;
            $display("FAIL %0t outstanding expected <= %0d actual wr %0d rd %0d", $time,
                     MAX_TRANS, $sampled(wr_outst), $sampled(rd_outst));
        end

    chk_drained: assert property (@(posedge seq) disable iff (!rst_n)
        pause_ack |-> wr_outst == 0 && rd_outst == 0)
        else begin
            errors++;
            $display("%0t: pause_ack high with transactions still outstanding", $time);
        end

    chk_paused_quiet: assert property (@(posedge seq) disable iff (!rst_n)
        pause_ack |-> !(aw_valid && aw_ready) && !(w_valid && w_ready)
                      && !(ar_valid && ar_ready))
        else begin
            errors++;
            $display("%0t: request handshake while paused", $time);
        end

    chk_resume: assert property (@(posedge seq) disable iff (!rst_n)
        !pause_req && pause_ack |=> !pause_ack)
        else begin
            errors++;
            $display("FAIL %0t pause_ack expected 0 actual 1", $time);
        end

    chk_b_hold: assert property (@(posedge seq) disable iff (!rst_n)
        b_valid && !b_ready |=> b_valid && $stable(b_resp))
        else begin
            errors++;
            $display("%0t: stalled B response dropped or changed", $time);
        end

    chk_r_hold: assert property (@(posedge seq) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_resp))
        else begin
            errors++;
            $display("%0t: stalled R beat dropped or changed", $time);
        end

    task automatic drive_write(input addr_t addr, input data_t data, input strb_t strb);
        int start;
        start    = wr_hs;
        aw_addr  = addr;
        aw_prot  = 3'b000;
        w_data   = data;
        w_strb   = strb;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        while (wr_hs == start) @(negedge seq);
    endtask

    task automatic drive_read(input addr_t addr);
        int start;
        start    = rd_hs;
        ar_addr  = addr;
        ar_prot  = 3'b000;
        ar_valid = 1'b1;
        while (rd_hs == start) @(negedge seq);
    endtask

    task automatic write_stream(input int first, input int count);
        for (int i = first; i < first + count; i++) begin
            drive_write(wr_addr_tab[i], wr_data_tab[i], wr_strb_tab[i]);
        end
        aw_valid = 1'b0;
        w_valid  = 1'b0;
    endtask

    task automatic read_stream(input int first, input int count);
        for (int i = first; i < first + count; i++) begin
            drive_read(rd_addr_tab[i]);
        end
        ar_valid = 1'b0;
    endtask

    task automatic stall_responses();
        while (!streams_done) begin
            b_ready = ($random(seed) & 3) != 0;
            r_ready = ($random(seed) & 3) != 0;
            @(negedge seq);
        end
        b_ready = 1'b1;
        r_ready = 1'b1;
    endtask

    task automatic run_traffic(input int first, input int count);
        streams_done = 1'b0;
        fork
            begin
                fork
                    write_stream(first, count);
                    read_stream(first, count);
                join
                streams_done = 1'b1;
            end
            stall_responses();
        join
    endtask

    task automatic release_boot_pause(input int wait_cyc);
        repeat (wait_cyc) @(negedge seq);
        boot_phase = 1'b0;
        pause_req  = 1'b0;
    endtask

    task automatic pause_midway(input int lead, input int hold);
        repeat (lead) @(negedge seq);
        pause_req = 1'b1;
        while (!pause_ack) @(negedge seq);
        repeat (hold) @(negedge seq);
        pause_req = 1'b0;
    endtask

    task automatic read_back_all();
        for (int i = 0; i < REG_COUNT; i++) begin
            drive_read(addr_t'(i << IDX_LSB));
        end
        ar_valid = 1'b0;
    endtask

    // Watchdog
    initial begin
        #(WDOG_CYC * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, traffic stalled, %0d errors so far",
                 WDOG_CYC, errors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed         = 32'h6cfb;
        errors       = 0;
        wr_hs        = 0;
        rd_hs        = 0;
        wr_outst     = 0;
        rd_outst     = 0;
        boot_phase   = 1'b1;
        streams_done = 1'b0;
        exp_b_head   = RESP_OKAY;
        exp_rd_head  = '0;
        exp_rr_head  = RESP_OKAY;
        rst_n        = 1'b0;
        pause_req    = 1'b1;
        aw_addr      = '0;
        aw_prot      = '0;
        aw_valid     = 1'b0;
        w_data       = '0;
        w_strb       = '0;
        w_valid      = 1'b0;
        b_ready      = 1'b1;
        ar_addr      = '0;
        ar_prot      = '0;
        ar_valid     = 1'b0;
        r_ready      = 1'b1;
        for (int i = 0; i < REG_COUNT; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < 2 * N_RAND; i++) begin
            wr_addr_tab[i] = pick_addr();
            wr_data_tab[i] = $random(seed);
            wr_strb_tab[i] = strb_t'($random(seed));
            rd_addr_tab[i] = pick_addr();
        end

        // Three rising edges in reset, release on the falling edge after
        repeat (3) @(posedge seq);
        @(negedge seq);
        rst_n = 1'b1;

        // First transactions wait at the closed ports until the resume
        fork
            release_boot_pause(5);
            run_traffic(0, N_RAND);
        join

        fork
            pause_midway(12, 10);
            run_traffic(N_RAND, N_RAND);
        join

        read_back_all();
        while (wr_outst != 0 || rd_outst != 0) @(negedge seq);
        repeat (2) @(negedge seq);

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
source/axil_pkg.sv
source/regmap_pkg.sv
source/axil_if.sv
source/axil_pause_gate.sv
source/axil_reg_target.sv
source/axil_pause_top.sv
testbench/tb_axil_pause_top.sv

//--- Bender.yml
package:
  name: axil_pause

sources:
  - source/axil_pkg.sv
  - source/regmap_pkg.sv
  - source/axil_if.sv
  - source/axil_pause_gate.sv
  - source/axil_reg_target.sv
  - source/axil_pause_top.sv
  - target: test
    files:
      - testbench/tb_axil_pause_top.sv
